//--- project.f
+incdir+include
hdl/aui_am_pkg.sv
hdl/aui_fec_pkg.sv
hdl/aui_am_lane_monitor.sv
hdl/aui_lane_mapper.sv
hdl/aui_codeword_deinterleave.sv
hdl/aui_block_serializer.sv
hdl/aui_checker_top.sv
tests/aui_checker_asserts.sv
tests/aui_checker_tb.sv

//--- run.sh
#!/bin/sh
# Build the AUI checker testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f project.f --top-module aui_checker_tb -o aui_sim

# Simulation output is kept in memory and searched for the pass line
out=$(./obj_dir/aui_sim || true)
echo "$out"
if echo "$out" | grep -q "TESTS PASSED"; then
    exit 0
fi
exit 1

//--- tests/aui_checker_tb.sv
`timescale 1ns/1ps
`include "aui_config.svh"

module aui_checker_tb;

    localparam int CMP_W = 2 * `AUI_BLOCK_W;                         // Widest compared value
    localparam int GAP   = `AUI_AM_PERIOD + 1;                       // Good sync spacing
    localparam int SYMS  = (`AUI_CW_W - `AUI_FEC_W) / `AUI_SYM_W;    // Data symbols per codeword
    localparam int RAW_W = 32 * ((`AUI_LANE_W + 31) / 32);

    logic                         clk;
    logic                         rst;
    aui_am_pkg::lane_bus_t        lanes;
    logic [`AUI_LANES-1:0]        sync;
    logic                         valid;
    aui_am_pkg::lane_status_vec_t status;
    aui_am_pkg::lane_map_t        lane_map;
    logic [`AUI_LANES-1:0]        map_valid;
    aui_fec_pkg::block_pair_t     block;
    logic                         block_valid;
    logic                         block_last;
    logic                         frame_drop;

    integer seed = 9;
    int     errors = 0;
    int     checks = 0;
    int     tests = 0;
    int     failed = 0;
    int     err_mark = 0;   // Error count when the current test began

    // Marker model state per physical lane
    logic                         seen_m [`AUI_LANES];
    aui_am_pkg::am_t              prev_m [`AUI_LANES];
    aui_am_pkg::lane_status_vec_t status_m;
    aui_am_pkg::lane_map_t        map_m;
    logic [`AUI_LANES-1:0]        map_valid_m;
    aui_fec_pkg::block_pair_t     exp_q [$];   // Block pairs still to come out

    aui_checker_top u_aui_checker_top (
        .clk (clk), .rst (rst), .i_lanes (lanes), .i_sync (sync), .i_valid (valid),
        .o_status (status), .o_lane_map (lane_map), .o_map_valid (map_valid),
        .o_block (block), .o_block_valid (block_valid), .o_block_last (block_last),
        .o_frame_drop (frame_drop)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check(input string name, input logic [CMP_W-1:0] exp,
                         input logic [CMP_W-1:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    function automatic logic [`AUI_LANE_W-1:0] random_lane();
        logic [RAW_W-1:0] raw;
        for (int w = 0; w < RAW_W / 32; w++) begin
            raw[32*w +: 32] = $random(seed);
        end
        return raw[`AUI_LANE_W-1:0];
    endfunction

    // Flow f symbol 2i+h is data symbol i of codeword 2f+h
    // That symbol sits in lane i mod 16 at lane symbol 4*(i div 16) + codeword
    function automatic aui_fec_pkg::flow_pair_t model_flows(input aui_am_pkg::lane_bus_t ln,
                                                             input logic am);
        aui_fec_pkg::flow_pair_t fp;
        int s;
        fp.has_am = am;
        for (int i = 0; i < SYMS; i++) begin
            for (int h = 0; h < 2; h++) begin
                s = `AUI_CODEWORDS * (i / `AUI_LANES) + h;
                fp.flow0[`AUI_SYM_W*(2*i+h) +: `AUI_SYM_W] =
                    ln[i % `AUI_LANES][`AUI_SYM_W*s +: `AUI_SYM_W];
                fp.flow1[`AUI_SYM_W*(2*i+h) +: `AUI_SYM_W] =
                    ln[i % `AUI_LANES][`AUI_SYM_W*(s+2) +: `AUI_SYM_W];   // Codewords C and D
            end
        end
        return fp;
    endfunction

    // Marker rules for one sync on lane p with the gap in cycles since its last sync
    task automatic model_sync(input int p, input aui_am_pkg::am_t am, input int gap);
        logic hit;
        int   k;
        hit = 1'b0;
        k   = 0;
        for (int t = 0; t < `AUI_LANES; t++) begin
            if (aui_am_pkg::AM_TABLE[t] == am) begin
                hit = 1'b1;
                k   = t;
            end
        end
        if (!hit || (seen_m[p] && am != prev_m[p])) status_m[p].am_err = 1'b1;
        if (seen_m[p] && gap != GAP) status_m[p].gap_err = 1'b1;
        if (status_m[p].am_err || status_m[p].gap_err) begin
            status_m[p].locked = 1'b0;                 // Lost for good
        end else if (seen_m[p]) begin
            status_m[p].locked = 1'b1;
        end
        if (hit) begin
            map_m[k]       = aui_am_pkg::lane_idx_t'(p);   // Ascending p so the higher lane wins
            map_valid_m[k] = 1'b1;
        end
        seen_m[p] = 1'b1;
        prev_m[p] = am;
    endtask

    task automatic reset_dut();
        rst   = 1'b1;
        sync  = '0;
        valid = 1'b0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        for (int p = 0; p < `AUI_LANES; p++) begin
            seen_m[p] = 1'b0;
        end
        status_m    = '0;
        map_m       = '0;
        map_valid_m = '0;
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == err_mark) begin
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // Two syncs per lane on a shuffled marker layout
    // A negative lane number means no such fault
    task automatic lock_test(input int gap_lane, input int bad_lane, input int chg_lane);
        int              perm [`AUI_LANES];
        int              sync_at [`AUI_LANES];   // Cycle of the second sync
        int              j;
        int              tmp;
        aui_am_pkg::am_t am;
        reset_dut();
        for (int p = 0; p < `AUI_LANES; p++) begin
            perm[p]    = p;
            sync_at[p] = GAP;
            lanes[p]   = random_lane();
        end
        for (int p = `AUI_LANES - 1; p > 0; p--) begin   // Fisher-Yates shuffle
            j       = int'($unsigned($random(seed)) % (p + 1));
            tmp     = perm[p];
            perm[p] = perm[j];
            perm[j] = tmp;
        end
        if (gap_lane >= 0) sync_at[gap_lane] = GAP - 1 - int'($unsigned($random(seed)) % 256);
        for (int c = 0; c <= GAP; c++) begin
            for (int p = 0; p < `AUI_LANES; p++) begin
                sync[p] = (c == 0) || (c == sync_at[p]);
                if (sync[p]) begin
                    am = aui_am_pkg::AM_TABLE[perm[p]];
                    if (c > 0 && p == bad_lane) begin
                        am = aui_am_pkg::am_t'({$random(seed), $random(seed),
                                                $random(seed), $random(seed)});
                    end
                    if (c > 0 && p == chg_lane) begin
                        am = aui_am_pkg::AM_TABLE[(perm[p] + 1) % `AUI_LANES];
                    end
                    lanes[p][`AUI_AM_W-1:0] = am;
                    model_sync(p, am, c);
                end else begin
                    lanes[p][31:0] = $random(seed);   // Filler between markers
                end
            end
            @(negedge clk);
        end
        sync = '0;
        check("o_status", CMP_W'(status_m), CMP_W'(status));
        check("o_lane_map", CMP_W'(map_m), CMP_W'(lane_map));
        check("o_map_valid", CMP_W'(map_valid_m), CMP_W'(map_valid));
    endtask

    // One frame plus, for drop_at >= 0, a second one offered at output pair drop_at
    task automatic frame_test(input logic with_am, input int drop_at);
        aui_fec_pkg::flow_pair_t  fp;
        aui_fec_pkg::block_pair_t bp;
        int                       n;
        int                       wait_cnt;
        for (int p = 0; p < `AUI_LANES; p++) begin
            lanes[p] = random_lane();
        end
        sync  = with_am ? (16'($random(seed)) | 16'h1) : '0;
        valid = 1'b1;
        fp    = model_flows(lanes, with_am);
        for (int b = (with_am ? `AUI_AM_BLOCKS : 0); b < `AUI_BLOCKS; b++) begin
            bp.blk0 = fp.flow0[`AUI_BLOCK_W*b +: `AUI_BLOCK_W];
            bp.blk1 = fp.flow1[`AUI_BLOCK_W*b +: `AUI_BLOCK_W];
            exp_q.push_back(bp);
        end
        n = exp_q.size();
        @(negedge clk);
        valid    = 1'b0;
        sync     = '0;
        wait_cnt = 0;
        while (!block_valid && wait_cnt < 8) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!block_valid) begin
            $display("Timeout while waiting for the first block pair of a frame");
            errors++;
            exp_q.delete();
        end else begin
            // First pair two cycles after the frame strobe
            check("o_block_valid delay", CMP_W'(1), CMP_W'(wait_cnt));
            for (int k = 0; k < n; k++) begin
                check("o_block_valid", CMP_W'(1'b1), CMP_W'(block_valid));
                check("o_block", CMP_W'(exp_q.pop_front()), CMP_W'(block));
                check("o_block_last", CMP_W'(k == n - 1), CMP_W'(block_last));
                check("o_frame_drop", CMP_W'(drop_at >= 0 && k == drop_at + 1),
                      CMP_W'(frame_drop));
                valid = (k == drop_at);                    // Frame that must be dropped
                if (valid) begin
                    for (int p = 0; p < `AUI_LANES; p++) begin
                        lanes[p] = random_lane();
                    end
                end
                @(negedge clk);
            end
            valid = 1'b0;
            check("o_block_valid", '0, CMP_W'(block_valid));   // No extra pairs
            check("o_frame_drop", '0, CMP_W'(frame_drop));
        end
    endtask

    initial begin
        int bad;
        int chg;
        rst   = 1'b1;
        lanes = '0;
        sync  = '0;
        valid = 1'b0;
        reset_dut();
        check("o_status", '0, CMP_W'(status));
        check("o_map_valid", '0, CMP_W'(map_valid));
        check("o_block_valid", '0, CMP_W'(block_valid));
        check("o_block_last", '0, CMP_W'(block_last));
        check("o_frame_drop", '0, CMP_W'(frame_drop));
        end_test("reset state");
        lock_test(-1, -1, -1);
        end_test("lock and mapping");
        lock_test(int'($unsigned($random(seed)) % `AUI_LANES), -1, -1);
        end_test("gap error");
        bad = int'($unsigned($random(seed)) % `AUI_LANES);
        chg = (bad + 1 + int'($unsigned($random(seed)) % (`AUI_LANES - 1))) % `AUI_LANES;
        lock_test(-1, bad, chg);
        end_test("marker errors");
        repeat (6) begin
            frame_test(1'b0, -1);
            repeat (3) @(negedge clk);   // Idle gap between frames
        end
        end_test("plain frames");
        frame_test(1'b1, -1);
        frame_test(1'b1, 10);
        frame_test(1'b0, 20);
        end_test("marker frames and drops");
        $display("%0d tests, %0d failed, %0d checks, %0d errors", tests, failed, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- tests/aui_checker_asserts.sv
`timescale 1ns/1ps
`include "aui_config.svh"

module aui_checker_asserts (
    input logic                         clk,
    input logic                         rst,
    input aui_am_pkg::lane_status_vec_t i_status,
    input logic                         i_block_valid,   // Same as serializer busy
    input logic                         i_block_last,
    input logic                         i_frame_drop,
    input logic                         i_flows_valid    // Frame offered to serializer
);

    a_last_in_frame: assert property (@(posedge clk) disable iff (rst)
        i_block_last |-> i_block_valid)
        else $error("o_block_last seen without o_block_valid");

    // Drops only while a frame is still going out
    a_drop_when_busy: assert property (@(posedge clk) disable iff (rst)
        i_frame_drop |-> i_block_valid)
        else $error("o_frame_drop raised while serializer idle");

    // Idle serializer always takes the offered frame
    a_capture_starts: assert property (@(posedge clk) disable iff (rst)
        (i_flows_valid && !i_block_valid) |=> i_block_valid)
        else $error("Frame offered to idle serializer was not sent");

    generate
        for (genvar g = 0; g < `AUI_LANES; g++) begin : g_lane
            a_lock_clean: assert property (@(posedge clk) disable iff (rst)
                i_status[g].locked |-> !(i_status[g].gap_err || i_status[g].am_err))
                else $error("Lane %0d locked with an error flag set", g);
        end
    endgenerate

endmodule

bind aui_checker_top aui_checker_asserts u_checker_asserts (
    .clk           (clk),
    .rst           (rst),
    .i_status      (o_status),
    .i_block_valid (o_block_valid),
    .i_block_last  (o_block_last),
    .i_frame_drop  (o_frame_drop),
    .i_flows_valid (flows_valid)
);

//--- hdl/aui_checker_top.sv
`timescale 1ns/1ps
`include "aui_config.svh"

module aui_checker_top (
    input  logic                         clk,
    input  logic                         rst,
    input  aui_am_pkg::lane_bus_t        i_lanes,
    input  logic [`AUI_LANES-1:0]        i_sync,        // Marker strobe per lane
    input  logic                         i_valid,       // Frame strobe
    output aui_am_pkg::lane_status_vec_t o_status,
    output aui_am_pkg::lane_map_t        o_lane_map,
    output logic [`AUI_LANES-1:0]        o_map_valid,
    output aui_fec_pkg::block_pair_t     o_block,
    output logic                         o_block_valid,
    output logic                         o_block_last,
    output logic                         o_frame_drop
);

    logic [`AUI_LANES-1:0]                  am_hit;       // Per physical lane
    aui_am_pkg::lane_idx_t [`AUI_LANES-1:0] am_id;
    aui_fec_pkg::flow_pair_t                flows;        // Deinterleaved frame
    logic                                   flows_valid;

    // One marker checker per physical lane
    generate
        for (genvar g = 0; g < `AUI_LANES; g++) begin : g_lane
            aui_am_lane_monitor u_lane_monitor (
                .clk      (clk),
                .rst      (rst),
                .i_sync   (i_sync[g]),
                .i_am     (i_lanes[g][`AUI_AM_W-1:0]),   // Marker in low bits
                .o_status (o_status[g]),
                .o_hit    (am_hit[g]),
                .o_am_id  (am_id[g])
            );
        end
    endgenerate

    aui_lane_mapper u_lane_mapper (
        .clk         (clk),
        .rst         (rst),
        .i_hit       (am_hit),
        .i_am_id     (am_id),
        .o_lane_map  (o_lane_map),
        .o_map_valid (o_map_valid)
    );

    // Data path, registered flows then block pairs
    aui_codeword_deinterleave u_codeword_deinterleave (
        .clk     (clk),
        .rst     (rst),
        .i_lanes (i_lanes),
        .i_sync  (i_sync),
        .i_valid (i_valid),
        .o_flows (flows),
        .o_valid (flows_valid)
    );

    aui_block_serializer u_block_serializer (
        .clk           (clk),
        .rst           (rst),
        .i_flows       (flows),
        .i_valid       (flows_valid),
        .o_block       (o_block),
        .o_block_valid (o_block_valid),
        .o_block_last  (o_block_last),
        .o_frame_drop  (o_frame_drop)
    );

endmodule

//--- hdl/aui_block_serializer.sv
`timescale 1ns/1ps
`include "aui_config.svh"

module aui_block_serializer (
    input  logic                     clk,
    input  logic                     rst,
    input  aui_fec_pkg::flow_pair_t  i_flows,
    input  logic                     i_valid,        // New frame offered
    output aui_fec_pkg::block_pair_t o_block,
    output logic                     o_block_valid,
    output logic                     o_block_last,   // Final pair of the frame
    output logic                     o_frame_drop    // Frame lost, still sending
);

    localparam int IDX_W    = $clog2(`AUI_BLOCKS);
    localparam int LAST_IDX = `AUI_BLOCKS - 1;

    aui_fec_pkg::flow_pair_t flows_q;   // Frame being sent
    logic                    busy;      // Capture up to last output
    logic [IDX_W-1:0]        blk_idx;   // Block currently on the output
    logic                    capture;

    assign capture = i_valid & ~busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy    <= 1'b0;
            blk_idx <= '0;
        end else if (capture) begin
            busy    <= 1'b1;
            // Marker frames skip the leading marker blocks
            blk_idx <= i_flows.has_am ? IDX_W'(`AUI_AM_BLOCKS) : '0;
        end else if (busy) begin
            if (blk_idx == IDX_W'(LAST_IDX)) begin
                busy <= 1'b0;              // Done after this pair
            end else begin
                blk_idx <= blk_idx + 1'b1;
            end
        end
    end

    // Frame storage, held until the next capture
    always_ff @(posedge clk) begin
        if (capture) begin
            flows_q <= i_flows;
        end
    end

    // Block b occupies flow bits 257b up to 257b+256
    assign o_block.blk0  = flows_q.flow0[blk_idx*`AUI_BLOCK_W +: `AUI_BLOCK_W];
    assign o_block.blk1  = flows_q.flow1[blk_idx*`AUI_BLOCK_W +: `AUI_BLOCK_W];
    assign o_block_valid = busy;
    assign o_block_last  = busy && (blk_idx == IDX_W'(LAST_IDX));
    assign o_frame_drop  = i_valid & busy;   // No back-pressure, just report

endmodule

//--- hdl/aui_codeword_deinterleave.sv
`timescale 1ns/1ps
`include "aui_config.svh"

module aui_codeword_deinterleave (
    input  logic                     clk,
    input  logic                     rst,
    input  aui_am_pkg::lane_bus_t    i_lanes,
    input  logic [`AUI_LANES-1:0]    i_sync,
    input  logic                     i_valid,   // Full frame on i_lanes
    output aui_fec_pkg::flow_pair_t  o_flows,
    output logic                     o_valid    // One pulse per frame
);

    localparam int ROUNDS    = `AUI_LANE_W / (`AUI_SYM_W * `AUI_CODEWORDS); // 34 per lane
    localparam int DATA_W    = `AUI_CW_W - `AUI_FEC_W;                       // 5140
    localparam int DATA_SYMS = DATA_W / `AUI_SYM_W;                          // 514

    logic [`AUI_CW_W-1:0]    cw      [`AUI_CODEWORDS];  // A, B, C, D with parity
    aui_fec_pkg::cw_data_t   cw_data [`AUI_CODEWORDS];  // Parity removed
    aui_fec_pkg::flow_pair_t flows_d;

    // Lane symbol 4r+c goes to codeword c as symbol 16r+j from the MSB
    always_comb begin
        for (int c = 0; c < `AUI_CODEWORDS; c++) begin
            for (int r = 0; r < ROUNDS; r++) begin
                for (int j = 0; j < `AUI_LANES; j++) begin
                    cw[c][`AUI_CW_W - `AUI_SYM_W*(`AUI_LANES*r + j) - 1 -: `AUI_SYM_W] =
                        i_lanes[j][`AUI_SYM_W*(`AUI_CODEWORDS*r + c) +: `AUI_SYM_W];
                end
            end
            cw_data[c] = cw[c][`AUI_CW_W-1 -: DATA_W];  // Drop low parity bits
        end
    end

    // Pair codewords into flows, MSB-first codeword symbols fill flow from LSB
    always_comb begin
        for (int i = 0; i < DATA_SYMS; i++) begin
            flows_d.flow0[2*`AUI_SYM_W*i +: `AUI_SYM_W] =
                cw_data[0][DATA_W - `AUI_SYM_W*i - 1 -: `AUI_SYM_W];                // A, even
            flows_d.flow0[2*`AUI_SYM_W*i + `AUI_SYM_W +: `AUI_SYM_W] =
                cw_data[1][DATA_W - `AUI_SYM_W*i - 1 -: `AUI_SYM_W];                // B, odd
            flows_d.flow1[2*`AUI_SYM_W*i +: `AUI_SYM_W] =
                cw_data[2][DATA_W - `AUI_SYM_W*i - 1 -: `AUI_SYM_W];                // C, even
            flows_d.flow1[2*`AUI_SYM_W*i + `AUI_SYM_W +: `AUI_SYM_W] =
                cw_data[3][DATA_W - `AUI_SYM_W*i - 1 -: `AUI_SYM_W];                // D, odd
        end
        flows_d.has_am = |i_sync;  // Any lane marker means a marker frame
    end

    always_ff @(posedge clk) begin
        if (i_valid) begin
            o_flows <= flows_d;    // Only load on a real frame
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;    // Lines up with o_flows
        end
    end

endmodule

//--- hdl/aui_lane_mapper.sv
`timescale 1ns/1ps
`include "aui_config.svh"

module aui_lane_mapper (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic [`AUI_LANES-1:0]                   i_hit,       // Per physical lane
    input  aui_am_pkg::lane_idx_t [`AUI_LANES-1:0]  i_am_id,     // Marker seen per physical lane
    output aui_am_pkg::lane_map_t                   o_lane_map,  // Logical -> physical
    output logic [`AUI_LANES-1:0]                   o_map_valid  // Entry has been filled
);

    aui_am_pkg::lane_map_t   map_d;
    logic [`AUI_LANES-1:0]   valid_d;

    // Invert physical->marker hits into marker->physical
    // Ascending scan, so the highest hitting lane wins a tie
    always_comb begin
        map_d   = o_lane_map;
        valid_d = o_map_valid;
        for (int p = 0; p < `AUI_LANES; p++) begin
            if (i_hit[p]) begin
                map_d[i_am_id[p]]   = aui_am_pkg::lane_idx_t'(p);
                valid_d[i_am_id[p]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_lane_map  <= '0;
            o_map_valid <= '0;
        end else begin
            o_lane_map  <= map_d;     // Entries persist until rehit
            o_map_valid <= valid_d;
        end
    end

endmodule

//--- hdl/aui_am_lane_monitor.sv
`timescale 1ns/1ps
`include "aui_config.svh"

module aui_am_lane_monitor (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     i_sync,    // Marker present this cycle
    input  aui_am_pkg::am_t          i_am,      // Low bits of the lane
    output aui_am_pkg::lane_status_t o_status,
    output logic                     o_hit,     // Table match during sync
    output aui_am_pkg::lane_idx_t    o_am_id    // Matching table entry
);

    // One extra bit so a long gap saturates above the period
    localparam int GAP_W = $clog2(`AUI_AM_PERIOD + 1) + 1;

    logic                  tbl_hit;
    aui_am_pkg::lane_idx_t tbl_id;
    logic [GAP_W-1:0]      gap_cnt;     // Cycles since last sync
    logic                  seen;        // First sync already taken
    aui_am_pkg::am_t       prev_am;     // Marker from last sync
    logic                  gap_bad;
    logic                  am_bad;
    logic                  gap_err_d;
    logic                  am_err_d;

    // Markers are unique so at most one table entry matches
    always_comb begin
        tbl_hit = 1'b0;
        tbl_id  = '0;
        for (int k = 0; k < `AUI_LANES; k++) begin
            if (i_am == aui_am_pkg::AM_TABLE[k]) begin
                tbl_hit = 1'b1;
                tbl_id  = aui_am_pkg::lane_idx_t'(k);
            end
        end
    end

    assign o_hit   = i_sync & tbl_hit;
    assign o_am_id = tbl_id;

    // Gap only judged once a previous sync exists
    assign gap_bad   = seen && (gap_cnt != GAP_W'(`AUI_AM_PERIOD));
    // Unknown marker always bad
    // Changed marker only counts after the first sync
    assign am_bad    = !tbl_hit || (seen && (i_am != prev_am));
    assign gap_err_d = o_status.gap_err | gap_bad;
    assign am_err_d  = o_status.am_err | am_bad;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            gap_cnt  <= '0;
            seen     <= 1'b0;
            o_status <= '0;
        end else if (i_sync) begin
            gap_cnt          <= '0;            // Restart spacing count
            seen             <= 1'b1;
            o_status.gap_err <= gap_err_d;     // Sticky
            o_status.am_err  <= am_err_d;      // Sticky
            // Lock needs a second clean sync and any error drops it for good
            o_status.locked  <= (o_status.locked | seen) & ~gap_err_d & ~am_err_d;
        end else if (gap_cnt != '1) begin
            gap_cnt <= gap_cnt + 1'b1;         // Saturate on very long gaps
        end
    end

    // Marker of this sync, compared at the next one
    always_ff @(posedge clk) begin
        if (i_sync) begin
            prev_am <= i_am;
        end
    end

endmodule

//--- hdl/aui_fec_pkg.sv
`include "aui_config.svh"

package aui_fec_pkg;

    // Codeword after the parity tail is dropped, 5140b
    typedef logic [`AUI_CW_W-`AUI_FEC_W-1:0] cw_data_t;

    // Two codewords symbol-interleaved, 10280b
    typedef logic [2*(`AUI_CW_W-`AUI_FEC_W)-1:0] flow_t;

    // Both flows of one frame
    typedef struct packed {
        flow_t flow0;   // From codewords A and B
        flow_t flow1;   // From codewords C and D
        logic  has_am;  // Frame carried markers, skip leading blocks
    } flow_pair_t;

    typedef logic [`AUI_BLOCK_W-1:0] block_t;

    // One block from each flow, same block index
    typedef struct packed {
        block_t blk0;   // Flow 0
        block_t blk1;   // Flow 1
    } block_pair_t;

endpackage

//--- hdl/aui_am_pkg.sv
`include "aui_config.svh"

package aui_am_pkg;

    typedef logic [`AUI_AM_W-1:0] am_t;                  // One alignment marker
    typedef logic [$clog2(`AUI_LANES)-1:0] lane_idx_t;   // Lane or marker number

    // Per-lane result of the marker checks
    typedef struct packed {
        logic locked;   // Good gap and good marker seen
        logic gap_err;  // Sticky, wrong sync spacing
        logic am_err;   // Sticky, unknown or changed marker
    } lane_status_t;

    typedef lane_status_t [`AUI_LANES-1:0] lane_status_vec_t;     // Indexed by physical lane
    typedef lane_idx_t [`AUI_LANES-1:0] lane_map_t;               // Logical -> physical
    typedef logic [`AUI_LANES-1:0][`AUI_LANE_W-1:0] lane_bus_t;   // Whole lane bundle

    // Expected markers, already in arrival bit order
    // Entry k identifies logical lane k
    localparam am_t AM_TABLE [0:`AUI_LANES-1] = '{
        120'hF37101260C8EFED9D9B565B6264A9A,
        120'h7EDE5A988121A567D9B56504264A9A,
        120'h56F33E01A90CC1FED9B56546264A9A,
        120'hD080867B2F7F7984D9B5655A264A9A,
        120'hF2512AE60DAED519D9B565E1264A9A,
        120'hD14F12B12EB0ED4ED9B565F2264A9A,
        120'hA19C42115E63BDEED9B5653D264A9A,
        120'h5B76D6CDA4892932D9B56522264A9A,
        120'h7573E1608A8C1E9FD9B56560264A9A,
        120'h3CC4715DC33B8EA2D9B5656B264A9A,
        120'hD8EB95FB27146A04D9B565FA264A9A,
        120'h3866228EC799DD71D9B5656C264A9A,
        120'h95F6A2A46A095D5BD9B56518264A9A,
        120'hC39731333C68CECCD9B56514264A9A,
        120'hA6FBCA4E590435B1D9B565D0264A9A,
        120'h79BAA6A986455956D9B565B4264A9A
    };

endpackage

//--- include/aui_config.svh
`ifndef AUI_CONFIG_SVH
`define AUI_CONFIG_SVH

// Lane bundle as seen at the receive side
`define AUI_LANES      16     // Physical lanes, one marker each
`define AUI_LANE_W     1360   // Bits per lane per cycle
`define AUI_SYM_W      10     // Round-robin symbol size

// Reed-Solomon codeword geometry
`define AUI_CODEWORDS  4      // Codewords A, B, C, D
`define AUI_CW_W       5440   // Full codeword incl. parity
`define AUI_FEC_W      300    // Parity tail, low bits of a codeword

// Alignment markers
`define AUI_AM_W       120    // Marker sits in low bits of the lane

// Block layout of one flow
`define AUI_BLOCK_W    257    // One 257b block
`define AUI_BLOCKS     40     // Blocks per flow, 40 x 257 = 10280
`define AUI_AM_BLOCKS  4      // Leading blocks that hold markers

// Counter value at the next sync when the gap is right
// Syncs land 8192 cycles apart
`define AUI_AM_PERIOD  8191

`endif
